// ==== build.f ====
verilog/ahb_pkg.sv
verilog/matrix_pkg.sv
verilog/ahb_addr_if.sv
verilog/ahb_hold_stage.sv
verilog/ahb_burst_term.sv
verilog/ahb_input_stage.sv
testbench/tb_ahb_input_stage.sv

// ==== Makefile ====
# Verilator simulation of the AHB bus matrix input stage
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ahb_input_stage
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Done: errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/input_stage_cases.txt ====
// In:  hsel haddr htrans hsize hburst hreadys active_ip readyout_ip resp_ip
// Out: hreadyouts hresps sel_ip addr_ip trans_ip burst_ip held_tran_ip
// One line per clock cycle, all fields hex
0 00000000 0 2 0 1 1 1 0   1 0 0 00000000 0 0 0  // after reset
1 00000100 2 2 0 1 1 1 0   1 0 1 00000100 2 0 1  // pass through
1 00000104 2 2 0 0 1 0 0   0 0 1 00000104 2 0 0  // slave wait
1 00000104 2 2 0 1 1 1 0   1 0 1 00000104 2 0 1
1 00000200 2 2 0 1 0 1 0   1 0 1 00000200 2 0 1  // not granted, hold
0 00000000 0 2 0 0 0 1 0   0 0 1 00000200 2 0 1  // replay as NONSEQ
0 00000000 0 2 0 0 1 0 0   0 0 1 00000200 2 0 1
0 00000000 0 2 0 0 1 1 0   0 0 1 00000200 2 0 1
0 00000000 0 2 0 0 1 0 1   0 1 0 00000000 0 0 0  // error, first cycle
0 00000000 0 2 0 1 1 1 1   1 1 0 00000000 0 0 0  // error, second cycle
0 00000000 0 2 0 1 1 0 1   1 0 0 00000000 0 0 0  // no data phase
1 00000300 2 2 3 1 1 1 0   1 0 1 00000300 2 3 1  // INCR4 start
1 00000304 3 2 3 1 0 1 0   1 0 1 00000304 3 3 1  // SEQ not granted
1 00000308 3 2 3 0 1 1 0   0 0 1 00000304 2 1 1  // replay, burst INCR
1 00000308 3 2 3 1 1 1 0   1 0 1 00000308 3 1 1
1 0000030c 3 2 3 1 1 1 0   1 0 1 0000030c 3 1 1
1 00000400 2 2 0 1 1 1 0   1 0 1 00000400 2 0 1  // NONSEQ clears override
1 00000508 2 2 2 1 1 1 0   1 0 1 00000508 2 2 1  // WRAP4 start
1 0000050c 3 2 2 1 0 1 0   1 0 1 0000050c 3 2 1  // last beat before wrap
1 00000500 3 2 2 0 1 1 0   0 0 1 0000050c 2 1 1
1 00000500 3 2 2 1 1 1 0   1 0 1 00000500 2 1 1  // SEQ out as NONSEQ
1 00000504 3 2 2 1 1 1 0   1 0 1 00000504 3 1 1
0 00000000 0 2 0 1 1 1 0   1 0 0 00000000 0 1 0  // override still set
0 00000000 0 2 0 1 1 1 0   1 0 0 00000000 0 0 0

// ==== testbench/tb_ahb_input_stage.sv ====
/*
  Cycle based testbench of the AHB input stage, driven from a case file.
  Each case line is applied on a rising edge and checked at the falling edge.
  Write, protection and lock come from address bits 8 to 11 of each case.
*/
module tb_ahb_input_stage
  import ahb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    ADDR_WIDTH     = 32;
  localparam int    CLK_PERIOD     = 8;
  localparam int    RESET_CYCLES   = 10;
  localparam int    TIMEOUT_MARGIN = 20;   // Cycles beyond the case count
  localparam int    IN_FIELDS      = 9;    // Stimulus words per line
  localparam int    FIELDS         = 16;   // Stimulus plus expected
  localparam int    MAX_CASES      = 64;
  localparam int    CTRL_LSB       = 8;    // Address bit where side controls start
  localparam string CASE_FILE      = "testbench/input_stage_cases.txt";

  logic HCLK, HRESETn;
  logic HSELS, HWRITES, HMASTLOCKS, HREADYS, active_ip, readyout_ip;
  logic [ADDR_WIDTH-1:0] HADDRS, addr_ip;
  logic [1:0] HTRANSS, resp_ip, HRESPS, trans_ip;
  logic [HSIZE_W-1:0] HSIZES, size_ip;
  logic [2:0] HBURSTS, burst_ip;
  logic [HPROT_W-1:0] HPROTS, prot_ip;
  logic HREADYOUTS, sel_ip, write_ip, mastlock_ip, held_tran_ip;

  logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];  // FIELDS words per case line
  int num_cases   = 0;
  int error_count = 0;
  int check_count = 0;
  bit cases_ready = 1'b0;

  ahb_input_stage #(.ADDR_WIDTH(ADDR_WIDTH)) ahb_input_stage_i (
    .HCLK, .HRESETn, .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS,
    .HPROTS, .HMASTLOCKS, .HREADYS, .active_ip, .readyout_ip, .resp_ip,
    .HREADYOUTS, .HRESPS, .sel_ip, .addr_ip, .trans_ip, .write_ip, .size_ip,
    .burst_ip, .prot_ip, .mastlock_ip, .held_tran_ip
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD/2) HCLK = ~HCLK;
  end

  // --------------------------------------------------
  // Case file handling
  // --------------------------------------------------
  task automatic load_cases();
    for (int i = 0; i < MAX_CASES*FIELDS; i++)
      case_mem[i] = 32'hdead_0000 | i;  // Unread words end the list
    $readmemh(CASE_FILE, case_mem);
    // hsel is 0 or 1 on every real case line
    while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] <= 32'd1)
      num_cases++;
  endtask

  task automatic apply_case(input int n);
    int b;
    b = n * FIELDS;
    HSELS       <= case_mem[b][0];
    HADDRS      <= case_mem[b+1][ADDR_WIDTH-1:0];
    HTRANSS     <= case_mem[b+2][1:0];
    HSIZES      <= case_mem[b+3][HSIZE_W-1:0];
    HBURSTS     <= case_mem[b+4][2:0];
    HREADYS     <= case_mem[b+5][0];
    active_ip   <= case_mem[b+6][0];
    readyout_ip <= case_mem[b+7][0];
    resp_ip     <= case_mem[b+8][1:0];
    // Side controls ride along with the address
    HWRITES     <= case_mem[b+1][CTRL_LSB];
    HPROTS      <= case_mem[b+1][CTRL_LSB +: HPROT_W];
    HMASTLOCKS  <= case_mem[b+1][CTRL_LSB+1];
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAILED at %t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_case(input int n);
    int a;
    int b;
    a = n * FIELDS;
    b = a + IN_FIELDS;
    compare("HREADYOUTS", 32'(HREADYOUTS), case_mem[b]);
    compare("HRESPS", 32'(HRESPS), case_mem[b+1]);
    compare("sel_ip", 32'(sel_ip), case_mem[b+2]);
    compare("addr_ip", 32'(addr_ip), case_mem[b+3]);
    compare("trans_ip", 32'(trans_ip), case_mem[b+4]);
    compare("burst_ip", 32'(burst_ip), case_mem[b+5]);
    compare("held_tran_ip", 32'(held_tran_ip), case_mem[b+6]);
    // Held or live, these match the bits of the expected address
    compare("write_ip", 32'(write_ip), 32'(case_mem[b+3][CTRL_LSB]));
    compare("prot_ip", 32'(prot_ip), 32'(case_mem[b+3][CTRL_LSB +: HPROT_W]));
    compare("mastlock_ip", 32'(mastlock_ip), 32'(case_mem[b+3][CTRL_LSB+1]));
    compare("size_ip", 32'(size_ip), 32'(case_mem[a+3][HSIZE_W-1:0]));  // Size constant per burst
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    HRESETn = 1'b0;
    HSELS = 1'b0;
    HADDRS = '0;
    HTRANSS = 2'b00;
    HWRITES = 1'b0;     // Follows address bits once cases run
    HSIZES = '0;
    HBURSTS = 3'b000;
    HPROTS = 4'h3;
    HMASTLOCKS = 1'b0;
    HREADYS = 1'b1;
    active_ip = 1'b0;
    readyout_ip = 1'b1;
    resp_ip = 2'b00;
    load_cases();
    cases_ready = 1'b1;
    if (num_cases == 0)
    begin
      error_count++;
      $display("No cases could be read from %s", CASE_FILE);
    end
    repeat (RESET_CYCLES) @(posedge HCLK);
    HRESETn <= 1'b1;
    for (int n = 0; n < num_cases; n++)
    begin
      @(posedge HCLK);
      apply_case(n);
      @(negedge HCLK);  // Outputs settled mid cycle
      check_case(n);
    end
    @(posedge HCLK);
    $display("Cases: %0d, checks: %0d, errors: %0d", num_cases, check_count, error_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized from the case count
  initial
  begin
    wait (cases_ready);
    #((num_cases + TIMEOUT_MARGIN) * CLK_PERIOD);
    $display("Timeout: case sequence still running after %0d cycles",
             num_cases + TIMEOUT_MARGIN);
    $display("Cases: %0d, checks: %0d, errors: %0d", num_cases, check_count, error_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verilog/ahb_input_stage.sv ====
/*
  Input stage of an AHB bus matrix for one master port.
  No user address or master number is carried; ADDR_WIDTH must be 7 or more.
*/
module ahb_input_stage
  import ahb_pkg::*, matrix_pkg::*;
#(
  parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  // Master port address phase
  input  logic                  HSELS,
  input  logic [ADDR_WIDTH-1:0] HADDRS,
  input  logic [1:0]            HTRANSS,
  input  logic                  HWRITES,
  input  logic [HSIZE_W-1:0]    HSIZES,
  input  logic [2:0]            HBURSTS,
  input  logic [HPROT_W-1:0]    HPROTS,
  input  logic                  HMASTLOCKS,
  input  logic                  HREADYS,
  // From the output stage
  input  logic                  active_ip,
  input  logic                  readyout_ip,
  input  logic [1:0]            resp_ip,
  // Response to the master
  output logic                  HREADYOUTS,
  output logic [1:0]            HRESPS,
  // To the output stage
  output logic                  sel_ip,
  output logic [ADDR_WIDTH-1:0] addr_ip,
  output logic [1:0]            trans_ip,
  output logic                  write_ip,
  output logic [HSIZE_W-1:0]    size_ip,
  output logic [2:0]            burst_ip,
  output logic [HPROT_W-1:0]    prot_ip,
  output logic                  mastlock_ip,
  output logic                  held_tran_ip
);

  ahb_addr_if #(.ADDR_WIDTH(ADDR_WIDTH)) bus ();

  logic    load_reg;
  logic    pend_q;
  htrans_e trans_mux, trans_burst_src, trans_fix;
  hburst_e burst_mux, burst_fix;
  hresp_e  hresps;

  // Port bits into the bundle, enums cast here
  assign bus.hsel      = HSELS;
  assign bus.haddr     = HADDRS;
  assign bus.htrans    = htrans_e'(HTRANSS);
  assign bus.hwrite    = HWRITES;
  assign bus.hsize     = HSIZES;
  assign bus.hburst    = hburst_e'(HBURSTS);
  assign bus.hprot     = HPROTS;
  assign bus.hmastlock = HMASTLOCKS;
  assign bus.hready    = HREADYS;

  ahb_hold_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_hold (
    .HCLK, .HRESETn, .bus(bus.hold), .active_ip, .readyout_ip,
    .resp_ip(hresp_e'(resp_ip)), .load_reg, .pend_q, .held_tran_ip,
    .sel_ip, .addr_ip, .write_ip, .size_ip, .prot_ip, .mastlock_ip,
    .trans_mux, .burst_mux, .trans_burst_src, .HREADYOUTS, .HRESPS(hresps)
  );

  ahb_burst_term #(.ADDR_WIDTH(ADDR_WIDTH)) u_term (
    .HCLK, .HRESETn, .bus(bus.term), .load_reg, .active_ip,
    .trans_mux, .burst_mux, .trans_burst_src,
    .trans_ip(trans_fix), .burst_ip(burst_fix)
  );

  assign trans_ip = trans_fix;  // Back to plain bits
  assign burst_ip = burst_fix;
  assign HRESPS   = hresps;

endmodule

// ==== verilog/ahb_burst_term.sv ====
/*
  Rewrites a defined-length burst cut short by the output stage into INCR.
  Wrapping bursts get NONSEQ/IDLE at each wrap boundary; ADDR_WIDTH must be 7 or more.
*/
module ahb_burst_term
  import ahb_pkg::*, matrix_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic     HCLK,
  input  logic     HRESETn,
  ahb_addr_if.term bus,
  input  logic     load_reg,         // Accept strobe from holding stage
  input  logic     active_ip,
  input  htrans_e  trans_mux,
  input  hburst_e  burst_mux,
  input  htrans_e  trans_burst_src,
  output htrans_e  trans_ip,
  output hburst_e  burst_ip
);

  logic                  burst_override_q;  // Burst was interrupted
  logic                  burst_override_next;
  logic [WRAP_OFS_W-1:0] offset_addr;       // Beat index by size
  logic [WRAP_OFS_W-1:0] check_addr;        // Offset masked by wrap length
  logic                  bound_q;           // Previous beat ended a wrap window
  logic                  bound_next;
  logic                  bound_en;

  // Doubleword slice needs address bit 6
  if (ADDR_WIDTH < 7)
  begin : g_width_check
    $error("ADDR_WIDTH must be at least 7");
  end

  // --------------------------------------------------
  // Early burst termination
  // --------------------------------------------------
  assign burst_override_next =
    ((bus.htrans == NONSEQ) || (bus.htrans == IDLE))       ? 1'b0 :  // New burst or none
    ((bus.htrans == SEQ) && load_reg && !active_ip) ? 1'b1 :  // Burst broken
    burst_override_q;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override_q <= 1'b0;
    else if (bus.hready)
      burst_override_q <= burst_override_next;
  end

  assign burst_ip = (burst_override_q && (trans_burst_src != NONSEQ)) ? INCR : burst_mux;
  assign trans_ip = (burst_override_q && bound_q) ? htrans_e'({trans_mux[1], 1'b0})
                                                  : trans_mux;  // SEQ->NONSEQ, BUSY->IDLE

  // --------------------------------------------------
  // Wrap boundary checking
  // --------------------------------------------------
  always_comb
  begin
    case (bus.hsize)
      3'd0:    offset_addr = bus.haddr[WRAP_OFS_W-1:0];
      3'd1:    offset_addr = bus.haddr[WRAP_OFS_W:1];
      3'd2:    offset_addr = bus.haddr[WRAP_OFS_W+1:2];
      3'd3:    offset_addr = bus.haddr[WRAP_OFS_W+2:3];
      default: offset_addr = bus.haddr[WRAP_OFS_W-1:0];  // 128 bits and up, byte offset
    endcase
  end

  // Unused upper bits forced high so all ones marks the last beat
  always_comb
  begin
    case (bus.hburst)
      WRAP4:   check_addr = {2'b11, offset_addr[1:0]};
      WRAP8:   check_addr = {1'b1, offset_addr[2:0]};
      WRAP16:  check_addr = offset_addr;
      default: check_addr = '0;  // Incrementing never wraps
    endcase
  end

  assign bound_next = &check_addr;
  assign bound_en   = bus.htrans[1] & bus.hready;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound_q <= 1'b0;
    else if (bound_en)
      bound_q <= bound_next;
  end

  // Override state only moves with the master's ready
  a_override_stable: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !bus.hready |=> $stable(burst_override_q)
  ) else $error("burst override changed with HREADYS low");

endmodule

// ==== verilog/ahb_hold_stage.sv ====
/*
  Holds one accepted transfer while the output stage is busy and replays it as NONSEQ.
  Only one transfer is ever in flight; HREADYOUTS stays low until it is served.
*/
module ahb_hold_stage
  import ahb_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  ahb_addr_if.hold              bus,
  input  logic                  active_ip,        // Output stage serves this port
  input  logic                  readyout_ip,      // HREADYOUT from slave side
  input  hresp_e                resp_ip,          // HRESP from slave side
  output logic                  load_reg,         // Accept strobe
  output logic                  pend_q,           // Transfer waits in registers
  output logic                  held_tran_ip,     // Request to the output stage
  output logic                  sel_ip,
  output logic [ADDR_WIDTH-1:0] addr_ip,
  output logic                  write_ip,
  output logic [HSIZE_W-1:0]    size_ip,
  output logic [HPROT_W-1:0]    prot_ip,
  output logic                  mastlock_ip,
  output htrans_e               trans_mux,        // HTRANS before boundary fixup
  output hburst_e               burst_mux,        // HBURST before override
  output htrans_e               trans_burst_src,  // HTRANS seen by burst override
  output logic                  HREADYOUTS,
  output hresp_e                HRESPS
);

  htrans_e               reg_trans;
  logic [ADDR_WIDTH-1:0] reg_addr;
  logic                  reg_write;
  logic [HSIZE_W-1:0]    reg_size;
  hburst_e               reg_burst;
  logic [HPROT_W-1:0]    reg_prot;
  logic                  reg_mastlock;
  logic                  addr_valid;   // Active address phase to this port
  logic                  data_valid;   // Active data phase to this port
  logic                  pend_next;

  // --------------------------------------------------
  // Holding registers
  // --------------------------------------------------
  assign addr_valid = bus.hsel & bus.htrans[1];  // NONSEQ or SEQ only
  assign load_reg   = addr_valid & bus.hready;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      reg_trans    <= IDLE;
      reg_addr     <= '0;
      reg_write    <= 1'b0;
      reg_size     <= '0;
      reg_burst    <= SINGLE;
      reg_prot     <= '0;
      reg_mastlock <= 1'b0;
    end
    else if (load_reg)
    begin
      reg_trans    <= bus.htrans;
      reg_addr     <= bus.haddr;
      reg_write    <= bus.hwrite;
      reg_size     <= bus.hsize;
      reg_burst    <= bus.hburst;
      reg_prot     <= bus.hprot;
      reg_mastlock <= bus.hmastlock;
    end
  end

  // Data phase follows address phase only on ready edges
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (bus.hready)
      data_valid <= addr_valid;
  end

  // --------------------------------------------------
  // Pending transfer tracking
  // --------------------------------------------------
  // Set when accepted but not taken, cleared once the slave completes it
  assign pend_next = (load_reg & ~active_ip)   ? 1'b1 :
                     (active_ip & readyout_ip) ? 1'b0 : pend_q;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else
      pend_q <= pend_next;
  end

  assign held_tran_ip = load_reg | pend_q;  // Live or held request

  // Output mux, registers win while a transfer waits
  always_comb
  begin
    if (!pend_q)
    begin
      sel_ip          = bus.hsel;
      trans_mux       = bus.htrans;
      addr_ip         = bus.haddr;
      write_ip        = bus.hwrite;
      size_ip         = bus.hsize;
      burst_mux       = bus.hburst;
      prot_ip         = bus.hprot;
      mastlock_ip     = bus.hmastlock;
      trans_burst_src = bus.htrans;
    end
    else
    begin
      sel_ip          = 1'b1;    // Held transfer always addressed here
      trans_mux       = NONSEQ;  // Replay starts a new burst
      addr_ip         = reg_addr;
      write_ip        = reg_write;
      size_ip         = reg_size;
      burst_mux       = reg_burst;
      prot_ip         = reg_prot;
      mastlock_ip     = reg_mastlock;
      trans_burst_src = reg_trans;  // Original type decides the override
    end
  end

  // --------------------------------------------------
  // Response generation
  // --------------------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;  // Idle, busy or not selected
      HRESPS     = OKAY;
    end
    else if (pend_q)
    begin
      HREADYOUTS = 1'b0;  // Stall the master
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // A held transfer must come from an accepted one
  a_pend_after_load: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $rose(pend_q) |-> $past(load_reg)
  ) else $error("pend_q rose without a load");

endmodule

// ==== verilog/ahb_addr_if.sv ====
/*
  Address phase signals of one AHB master port.
  Driven by the top level, read by the holding and the termination stage.
*/
interface ahb_addr_if
  import ahb_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
);

  logic                  hsel;       // Port selected by decoder
  logic [ADDR_WIDTH-1:0] haddr;
  htrans_e               htrans;
  logic                  hwrite;     // 1 for write
  logic [HSIZE_W-1:0]    hsize;
  hburst_e               hburst;
  logic [HPROT_W-1:0]    hprot;
  logic                  hmastlock;  // Locked sequence
  logic                  hready;     // Previous transfer done

  // Holding stage captures every field
  modport hold (
    input hsel, haddr, htrans, hwrite, hsize, hburst, hprot, hmastlock, hready
  );

  // Termination stage only needs what shapes the burst
  modport term (
    input htrans, haddr, hsize, hburst, hready
  );

endinterface

// ==== verilog/matrix_pkg.sv ====
/*
  Sizing defaults of the bus matrix input stage.
  The wrap offset covers bursts of up to 16 beats only.
*/
package matrix_pkg;

  // --------------------------------------------------
  // Address sizing
  // --------------------------------------------------
  // Default for the top level ADDR_WIDTH
  localparam int DEF_ADDR_WIDTH = 32;

  // --------------------------------------------------
  // Wrap boundary logic
  // --------------------------------------------------
  // Beat offset inside a wrap window
  // 4 bits hold the 16 beats of WRAP16
  localparam int WRAP_OFS_W = 4;

endpackage

// ==== verilog/ahb_pkg.sv ====
/*
  AHB-Lite protocol encodings shared by the input stage.
  RETRY and SPLIT are kept only so that a slave response passes through unchanged.
*/
package ahb_pkg;

  // --------------------------------------------------
  // Field widths
  // --------------------------------------------------
  localparam int HSIZE_W = 3;  // HSIZE, byte to 1024-bit
  localparam int HPROT_W = 4;  // HPROT, no extended bits

  // --------------------------------------------------
  // HTRANS
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master stalls mid burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Following beats
  } htrans_e;

  // HBURST, bit 0 set means incrementing
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // HRESP
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_e;

endpackage
